/* Makefile */
# Verilator simulation of the riscvCpu testbench

VERILATOR ?= verilator
TOP       ?= riscvCpuTb
FLAGS     ?= --timing
FILELIST  := riscvCpu.f
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

/* riscvCpu.f */
source/cpuConfigPkg.sv
source/isaPkg.sv
source/programCounter.sv
source/instructionMemory.sv
source/immediateGen.sv
source/registerFile.sv
source/alu.sv
source/controlUnit.sv
source/riscvCpu.sv
verification/riscvCpuTb.sv

/* source/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu #(
    parameter int dataWidth = cpuConfigPkg::xlen
) (
    input  logic [dataWidth-1:0] rs1Value,
    input  logic [dataWidth-1:0] rs2Value,
    input  logic [dataWidth-1:0] imm,
    input  logic                 aluSrc,     // 1 selects the immediate
    input  isaPkg::aluOpT        aluOp,
    output logic [dataWidth-1:0] result,
    output logic                 equal       // Branch compare flag
);

    import isaPkg::*;

    logic [dataWidth-1:0] operand2;
    logic                 lessThan;

    // Operand select, register or immediate
    assign operand2 = aluSrc ? imm : rs2Value;

    assign lessThan = $signed(rs1Value) < $signed(operand2);

    always_comb begin
        case (aluOp)
            aluAdd:  result = rs1Value + operand2;
            aluSub:  result = rs1Value - operand2;
            aluAnd:  result = rs1Value & operand2;
            aluOr:   result = rs1Value | operand2;
            aluSlt:  result = {{(dataWidth - 1){1'b0}}, lessThan};    // 0 or 1
            default: result = '0;
        endcase
    end

    // Always on the raw register values, whatever aluSrc says
    assign equal = (rs1Value == rs2Value);

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic              [6:0] opcode,
    input  logic              [2:0] funct3,
    input  logic                    funct7b5,     // instr[30]
    input  logic                    equal,        // From ALU
    output logic                    regWrite,
    output logic                    aluSrc,
    output isaPkg::immFormatT       immFormat,
    output isaPkg::aluOpT           aluOp,
    output logic                    branchTaken
);

    import isaPkg::*;

    aluOpT aluFromFunct3;                 // Shared by opImm and opReg
    logic  funct3Known;                   // funct3 in the supported subset
    logic  isReg;

    assign isReg = (opcode == opReg);

    always_comb begin
        funct3Known = 1'b1;
        case (funct3)
            f3AddSub: aluFromFunct3 = (isReg && funct7b5) ? aluSub : aluAdd;
            f3Slt:    aluFromFunct3 = aluSlt;
            f3Or:     aluFromFunct3 = aluOr;
            f3And:    aluFromFunct3 = aluAnd;
            default: begin
                aluFromFunct3 = aluAdd;
                funct3Known   = 1'b0;    // xor, shifts and the rest
            end
        endcase
    end

    always_comb begin
        regWrite    = 1'b0;               // No-op unless decoded below
        aluSrc      = 1'b0;
        immFormat   = immI;
        aluOp       = aluAdd;
        branchTaken = 1'b0;
        case (opcode)
            opImm: begin
                regWrite = funct3Known;
                aluSrc   = 1'b1;          // rs1 op imm
                aluOp    = aluFromFunct3;
            end
            opReg: begin
                regWrite = funct3Known;
                aluOp    = aluFromFunct3;  // rs1 op rs2
            end
            opBranch: begin
                immFormat = immB;         // Offset feeds the PC adder
                case (funct3)
                    f3Beq:   branchTaken = equal;
                    f3Bne:   branchTaken = !equal;
                    default: branchTaken = 1'b0;    // blt and friends fall through
                endcase
            end
            default: ;                    // Unknown opcode, PC + 4 only
        endcase
    end

endmodule

`default_nettype wire

/* source/cpuConfigPkg.sv */
`default_nettype none

package cpuConfigPkg;

    // Datapath width, also the PC width
    localparam int xlen = 32;

    // rs1, rs2 and rd field width
    localparam int regAddrWidth = 5;

    // Word address bits of the instruction store, 32 words
    localparam int imemDepthLog2Default = 5;

    // Register count and instruction width come from the ISA itself.
    // They stay fixed whatever the sizes above are set to.

endpackage

`default_nettype wire

/* source/immediateGen.sv */
`timescale 1ns/10ps
`default_nettype none

module immediateGen #(
    parameter int dataWidth = cpuConfigPkg::xlen
) (
    input  logic [31:0]          instr,
    input  isaPkg::immFormatT    immFormat,
    output logic [dataWidth-1:0] imm
);

    import isaPkg::*;

    logic [11:0]          immIField;     // I-type, 12 bits
    logic [12:0]          immBField;     // B-type, 13 bits with zero LSB
    logic [dataWidth-1:0] immIExt;
    logic [dataWidth-1:0] immBExt;

    assign immIField = instr[31:20];

    // Scattered branch bits, reassembled
    assign immBField = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // Sign bit is always instr[31]
    assign immIExt = {{(dataWidth - 12){immIField[11]}}, immIField};
    assign immBExt = {{(dataWidth - 13){immBField[12]}}, immBField};

    always_comb begin
        case (immFormat)
            immB:    imm = immBExt;        // Branch offset
            default: imm = immIExt;        // ALU immediate
        endcase
    end

endmodule

`default_nettype wire

/* source/instructionMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionMemory #(
    parameter int imemAddrWidth = cpuConfigPkg::imemDepthLog2Default
) (
    input  logic                     clk,
    input  logic                     writeEnable,    // Program load strobe
    input  logic [imemAddrWidth-1:0] writeAddr,      // Word address
    input  logic [31:0]              writeData,
    input  logic [imemAddrWidth-1:0] readAddr,       // Word index from the PC
    output logic [31:0]              instr
);

    localparam int depth = 2 ** imemAddrWidth;

    logic [31:0] mem [depth];            // Program storage, no reset

    // Load port, usable while the core sits in reset
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Fetch is combinational so decode completes in the same cycle
    assign instr = mem[readAddr];

endmodule

`default_nettype wire

/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opImm    = 7'b0010011,    // addi, andi, ori, slti
        opReg    = 7'b0110011,    // add, sub, and, or, slt
        opBranch = 7'b1100011     // beq, bne
    } opcodeT;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4             // Signed compare
    } aluOpT;

    // Which immediate layout to decode
    typedef enum logic {
        immI = 1'b0,              // 12-bit, instr[31:20]
        immB = 1'b1               // 13-bit branch offset
    } immFormatT;

    // funct3 codes, ALU group
    localparam logic [2:0] f3AddSub = 3'b000;    // funct7b5 picks sub on opReg
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 codes, branch group
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

endpackage

`default_nettype wire

/* source/programCounter.sv */
`timescale 1ns/10ps
`default_nettype none

module programCounter #(
    parameter int dataWidth = cpuConfigPkg::xlen
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 branchTaken,     // From control unit
    input  logic [dataWidth-1:0] branchOffset,    // B-type offset, already sign extended
    output logic [dataWidth-1:0] pc
);

    logic [dataWidth-1:0] pcPlus4;       // Sequential successor
    logic [dataWidth-1:0] pcTarget;      // Branch destination
    logic [dataWidth-1:0] pcNext;

    assign pcPlus4  = pc + dataWidth'(4);
    assign pcTarget = pc + branchOffset;  // PC relative, offset bit 0 is zero

    // Taken branch wins, otherwise fall through
    assign pcNext = branchTaken ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;                     // Fetch restarts at address 0
        end else begin
            pc <= pcNext;                 // One instruction per edge
        end
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile #(
    parameter int dataWidth = cpuConfigPkg::xlen
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                writeEnable,
    input  logic [cpuConfigPkg::regAddrWidth-1:0] readAddr1,    // rs1
    input  logic [cpuConfigPkg::regAddrWidth-1:0] readAddr2,    // rs2
    input  logic [cpuConfigPkg::regAddrWidth-1:0] writeAddr,    // rd
    input  logic [dataWidth-1:0]                writeData,
    output logic [dataWidth-1:0]                readData1,
    output logic [dataWidth-1:0]                readData2,
    output logic [dataWidth-1:0]                a0
);

    import cpuConfigPkg::*;

    localparam int regCount = 2 ** regAddrWidth;    // 32 architectural registers

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;            // Whole file clears
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData; // x0 writes dropped
        end
    end

    // Combinational reads
    assign readData1 = regs[readAddr1];   // x0 reads zero, never written
    assign readData2 = regs[readAddr2];

    // x10, visible right after the committing edge
    assign a0 = regs[10];

endmodule

`default_nettype wire

/* source/riscvCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module riscvCpu #(
    parameter int dataWidth     = cpuConfigPkg::xlen,
    parameter int imemAddrWidth = cpuConfigPkg::imemDepthLog2Default
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     progWrite,    // Program load strobe
    input  logic [imemAddrWidth-1:0] progAddr,     // Word address
    input  logic [31:0]              progData,
    output logic [dataWidth-1:0]     a0            // Register x10
);

    import isaPkg::*;

    logic [dataWidth-1:0] pc;
    logic [31:0]          instr;
    logic [dataWidth-1:0] imm;             // Sign extended immediate
    logic [dataWidth-1:0] rs1Value;
    logic [dataWidth-1:0] rs2Value;
    logic [dataWidth-1:0] result;          // ALU out, also writeback
    logic                 equal;
    logic                 regWrite;
    logic                 aluSrc;
    logic                 branchTaken;
    immFormatT            immFormat;
    aluOpT                aluOp;

    programCounter #(.dataWidth(dataWidth)) i_programCounter (
        .clk          (clk),
        .reset        (reset),
        .branchTaken  (branchTaken),
        .branchOffset (imm),               // B-type offset on branches
        .pc           (pc)
    );

    instructionMemory #(.imemAddrWidth(imemAddrWidth)) i_instructionMemory (
        .clk         (clk),
        .writeEnable (progWrite),
        .writeAddr   (progAddr),
        .writeData   (progData),
        .readAddr    (pc[imemAddrWidth+1:2]),    // Word index, byte bits dropped
        .instr       (instr)
    );

    immediateGen #(.dataWidth(dataWidth)) i_immediateGen (
        .instr     (instr),
        .immFormat (immFormat),
        .imm       (imm)
    );

    registerFile #(.dataWidth(dataWidth)) i_registerFile (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (regWrite),
        .readAddr1   (instr[19:15]),       // rs1
        .readAddr2   (instr[24:20]),       // rs2
        .writeAddr   (instr[11:7]),        // rd
        .writeData   (result),
        .readData1   (rs1Value),
        .readData2   (rs2Value),
        .a0          (a0)
    );

    alu #(.dataWidth(dataWidth)) i_alu (
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .imm      (imm),
        .aluSrc   (aluSrc),
        .aluOp    (aluOp),
        .result   (result),
        .equal    (equal)
    );

    controlUnit i_controlUnit (
        .opcode      (instr[6:0]),
        .funct3      (instr[14:12]),
        .funct7b5    (instr[30]),          // Sub versus add
        .equal       (equal),
        .regWrite    (regWrite),
        .aluSrc      (aluSrc),
        .immFormat   (immFormat),
        .aluOp       (aluOp),
        .branchTaken (branchTaken)
    );

endmodule

`default_nettype wire

/* verification/riscvCpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module riscvCpuTb;

    import cpuConfigPkg::*;

    localparam int clkHalfPeriod = 20;                        // 40 ns clock
    localparam int driveDelay    = 2;                         // Inputs move after the edge
    localparam int resetCycles   = 3;
    localparam int runLimit      = 1000;                      // Longest run command allowed
    localparam int lineLimit     = 1000;                      // Bound on the file reader
    localparam int imemWords     = 2 ** imemDepthLog2Default;

    logic                            clk;
    logic                            reset;
    logic                            progWrite;
    logic [imemDepthLog2Default-1:0] progAddr;
    logic [31:0]                     progData;
    logic [xlen-1:0]                 a0;

    int errorCount;
    int checkCount;
    int lineNumber;                                           // For messages
    int loadAddr;                                             // Next word to load

    riscvCpu i_dut (
        .clk       (clk),
        .reset     (reset),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .a0        (a0)
    );

    always #(clkHalfPeriod) clk = ~clk;

    // Counted wait on rising edges, ends 2 ns after the last one
    task automatic advanceCycles(input int cycles);
        int count;
        count = 0;
        while (count < cycles) begin
            if (count == runLimit) begin
                $display("Wait of %0d cycles on line %0d is longer than the %0d cycle limit",
                         cycles, lineNumber, runLimit);
                errorCount++;
                break;
            end
            @(posedge clk);
            #(driveDelay);
            count++;
        end
    endtask

    task automatic compareValue(input string name, input logic [xlen-1:0] actual,
                                input logic [xlen-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("error: %s is 0x%08h, expected 0x%08h (line %0d)",
                     name, actual, expected, lineNumber);
            errorCount++;
        end
    endtask

    task automatic applyReset();
        reset     = 1'b1;
        progWrite = 1'b0;
        loadAddr  = 0;                                        // Program restarts at word 0
        advanceCycles(resetCycles);
    endtask

    task automatic loadWord(input logic [31:0] word);
        if (!reset) begin
            $display("Load on line %0d while the core is out of reset", lineNumber);
            errorCount++;
        end else if (loadAddr >= imemWords) begin
            $display("Load on line %0d runs past the end of instruction memory", lineNumber);
            errorCount++;
        end else begin
            progWrite = 1'b1;
            progAddr  = loadAddr[imemDepthLog2Default-1:0];
            progData  = word;
            advanceCycles(1);                                 // Written on this edge
            progWrite = 1'b0;
            loadAddr++;
        end
    endtask

    // Drop line ending and trailing blanks
    function automatic string trimLine(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == 8'h0a || r.getc(r.len() - 1) == 8'h0d
                               || r.getc(r.len() - 1) == 8'h20)) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    task automatic executeLine(input string line);
        string       cmd;
        logic [31:0] value;
        int          cycles;
        int          fields;
        fields = $sscanf(line, "%s", cmd);
        if (fields == 1 && cmd == "title") begin
            $display("Test: %s", line.substr(6, line.len() - 1));
        end else if (fields == 1 && cmd == "reset") begin
            applyReset();
        end else if (cmd == "load" && $sscanf(line, "%s %h", cmd, value) == 2) begin
            loadWord(value);
        end else if (cmd == "run" && $sscanf(line, "%s %d", cmd, cycles) == 2) begin
            reset = 1'b0;                                     // Next edge runs address 0
            advanceCycles(cycles);
        end else if (cmd == "expect" && $sscanf(line, "%s %h", cmd, value) == 2) begin
            compareValue("a0", a0, value);
        end else begin
            $display("Malformed vector on line %0d: %s", lineNumber, line);
            errorCount++;
        end
    endtask

    initial begin
        int    fd;
        string line;
        clk        = 1'b0;
        reset      = 1'b1;
        progWrite  = 1'b0;
        progAddr   = '0;
        progData   = '0;
        errorCount = 0;
        checkCount = 0;
        lineNumber = 0;
        loadAddr   = 0;
        applyReset();                                         // Power-on reset
        fd = $fopen("verification/riscvCpuVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vectors file verification/riscvCpuVectors.txt");
            errorCount++;
        end else begin
            while (!$feof(fd) && lineNumber < lineLimit) begin
                lineNumber++;
                line = "";
                if ($fgets(line, fd) != 0) begin
                    line = trimLine(line);
                    if (line.len() != 0 && line.getc(0) != "#") begin
                        executeLine(line);                    // Comments and blanks skipped
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("Vectors file is longer than %0d lines", lineLimit);
                errorCount++;
            end
            $fclose(fd);
        end
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/riscvCpuVectors.txt */
# Commands: title <text> | reset | load <instr hex> | run <cycles decimal> | expect <a0 hex>
# load writes the next word from address 0 up, reset clears that address
title Reset state and I-type arithmetic
reset
expect 0
load 00500513
load ff950513
load 0f057513
load f0056513
load ff152513
load 00152513
run 0
expect 0
run 1
expect 5
run 3
expect fffffff0
run 1
expect 1
run 1
expect 0
title R-type arithmetic and x0
reset
load 06400593
load ffb00613
load 00c58533
load 40c58533
load 00c5f533
load 00c5e533
load 00b62533
load 00c5a533
load 00c58033
load 00058533
run 3
expect 5f
run 1
expect 69
run 1
expect 60
run 1
expect ffffffff
run 1
expect 1
run 1
expect 0
run 2
expect 64
title Forward beq and bne
reset
load 00100513
load 00100593
load 00b50463
load 01050513
load 00b51463
load 00250513
load 00b50463
load 00450513
load 00b51463
load 04050513
load 00850513
run 4
expect 1
run 5
expect f
title Backward branch loop
reset
load 00000513
load 00500593
load 00150513
load feb51ee3
load 10050513
run 12
expect 5
run 1
expect 105
title Program reload during reset
reset
expect 0
load 00350513
load 00350513
run 2
expect 6
